/* hw/accel_pkg.sv */
package accel_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////

   // data word on apb and wishbone
   typedef logic [31:0] word_t;

   // word address into the 256-word shared memory
   typedef logic [7:0] mem_addr_t;

   // register offset in paddr[7:0]
   typedef logic [7:0] reg_off_t;

   // prefix-sum engine fsm
   typedef enum logic [1:0] {
      idle,
      rd_req,
      wr_req,
      finished
   } eng_state_t;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////

   localparam reg_off_t REG_BASE_OFFSET = 8'h50;
   localparam reg_off_t REG_START       = 8'h54;
   localparam reg_off_t REG_STATUS      = 8'h58;

   // paddr bit that selects the memory window
   localparam int MEM_WINDOW_BIT = 12;

   // memory layout of the engine regions
   localparam mem_addr_t LANE_STRIDE = 8'd64;
   localparam mem_addr_t DST_OFFSET  = 8'd32;

endpackage

/* hw/wb_sram.sv */
`timescale 1ns/1ps

module wb_sram (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  accel_pkg::mem_addr_t adr,
   input  accel_pkg::word_t     dat_w,
   output logic                 ack,
   output accel_pkg::word_t     dat_r
);

   localparam int DEPTH = 2 ** $bits(accel_pkg::mem_addr_t);

   accel_pkg::word_t mem [DEPTH];
   logic             req;

   // new request only when no ack is pending
   assign req = cyc & stb & ~ack;

   always_ff @(posedge clk) begin
      if (!reset) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

   // write and read data land on the ack edge
   always_ff @(posedge clk) begin
      if (req) begin
         if (we) begin
            mem[adr] <= dat_w;
         end
         dat_r <= mem[adr];
      end
   end

endmodule

/* hw/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
   input  logic                       clk,
   input  logic                       reset,
   input  accel_pkg::mem_addr_t       base_offset,
   // master 0 is the host window, 1 and 2 the engines
   input  logic [2:0]                 m_cyc,
   input  logic [2:0]                 m_stb,
   input  logic [2:0]                 m_we,
   input  accel_pkg::mem_addr_t [2:0] m_adr,
   input  accel_pkg::word_t [2:0]     m_dat_w,
   output logic [2:0]                 m_ack,
   output accel_pkg::word_t           m_dat_r,
   output logic                       s_cyc,
   output logic                       s_stb,
   output logic                       s_we,
   output accel_pkg::mem_addr_t       s_adr,
   output accel_pkg::word_t           s_dat_w,
   input  logic                       s_ack,
   input  accel_pkg::word_t           s_dat_r
);

   logic [2:0] req;
   logic [1:0] gnt_q;
   logic       locked;
   logic [1:0] pick;
   logic [1:0] sel;
   logic       active;

   assign req = m_cyc & m_stb;

   // round-robin search from the master after the last grant
   always_comb begin
      int idx;
      pick = gnt_q;
      for (int i = 3; i >= 1; i--) begin
         idx = (int'(gnt_q) + i) % 3;
         if (req[idx]) begin
            pick = 2'(idx);
         end
      end
   end

   // gnt_q keeps the last grant once released
   always_ff @(posedge clk) begin
      if (!reset) begin
         locked <= 1'b0;
         gnt_q  <= 2'd2;
      end else if (!locked) begin
         if (|req) begin
            locked <= 1'b1;
            gnt_q  <= pick;
         end
      end else if (s_ack) begin
         locked <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // slave side mux
   //////////////////////////////////////////////////////////////////////

   assign sel    = locked ? gnt_q : pick;
   assign active = locked | (|req);

   assign s_cyc   = active & m_cyc[sel];
   assign s_stb   = active & m_stb[sel];
   assign s_we    = m_we[sel];
   assign s_dat_w = m_dat_w[sel];
   // engine addresses are relative, wrap at 256
   assign s_adr   = (sel == 2'd0) ? m_adr[0] : m_adr[sel] + base_offset;

   assign m_ack   = (active && s_ack) ? (3'b001 << sel) : 3'b000;
   // read data is shared, only the acked master takes it
   assign m_dat_r = s_dat_r;

   assert property (@(posedge clk) disable iff (!reset)
      $onehot0(m_ack) && ((m_ack & ~req) == 3'b000))
      else $error("ack routed to more than one master or to an idle one");

endmodule

/* hw/prefix_sum_engine.sv */
`timescale 1ns/1ps

module prefix_sum_engine #(
   parameter int LANE_ID   = 0,
   parameter int BLOCK_LEN = 8
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cluster_reset,
   input  logic                 run_en,
   output logic                 busy,
   output logic                 cyc,
   output logic                 stb,
   output logic                 we,
   output accel_pkg::mem_addr_t adr,
   output accel_pkg::word_t     dat_w,
   input  logic                 ack,
   input  accel_pkg::word_t     dat_r
);

   // start of this lane's region, relative to the base offset
   localparam accel_pkg::mem_addr_t REGION_BASE =
      accel_pkg::mem_addr_t'(LANE_ID * accel_pkg::LANE_STRIDE);
   localparam accel_pkg::mem_addr_t LAST_K = accel_pkg::mem_addr_t'(BLOCK_LEN - 1);

   accel_pkg::eng_state_t state;
   accel_pkg::mem_addr_t  k;
   accel_pkg::mem_addr_t  src_adr;
   accel_pkg::word_t      sum;
   accel_pkg::word_t      sum_next;

   assign src_adr  = REGION_BASE + k;
   assign sum_next = sum + dat_r;
   assign busy     = run_en & (state != accel_pkg::finished);

   //////////////////////////////////////////////////////////////////////
   // read, accumulate, write back
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset || cluster_reset) begin
         state <= accel_pkg::idle;
         k     <= '0;
         sum   <= '0;
         cyc   <= 1'b0;
         stb   <= 1'b0;
         we    <= 1'b0;
      end else if (run_en) begin
         case (state)
            accel_pkg::idle: begin
               // read source word k
               cyc   <= 1'b1;
               stb   <= 1'b1;
               we    <= 1'b0;
               adr   <= src_adr;
               state <= accel_pkg::rd_req;
            end
            accel_pkg::rd_req: begin
               if (ack) begin
                  cyc   <= 1'b0;
                  stb   <= 1'b0;
                  sum   <= sum_next;
                  dat_w <= sum_next;
                  state <= accel_pkg::wr_req;
               end
            end
            accel_pkg::wr_req: begin
               // stb stays low for one cycle after the read ack
               if (!stb) begin
                  cyc <= 1'b1;
                  stb <= 1'b1;
                  we  <= 1'b1;
                  adr <= src_adr + accel_pkg::DST_OFFSET;
               end else if (ack) begin
                  cyc <= 1'b0;
                  stb <= 1'b0;
                  we  <= 1'b0;
                  if (k == LAST_K) begin
                     state <= accel_pkg::finished;
                  end else begin
                     k     <= k + 1'b1;
                     state <= accel_pkg::idle;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   // request held stable under arbiter stall
   assert property (@(posedge clk) disable iff (!reset || cluster_reset)
      (stb && !ack) |=> (stb && cyc && $stable(adr) && $stable(we)))
      else $error("engine %0d request changed before ack", LANE_ID);

endmodule

/* hw/launch_sequencer.sv */
`timescale 1ns/1ps

module launch_sequencer #(
   parameter int RESET_DELAY = 4
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       start_pulse,
   input  logic [1:0] eng_busy,
   output logic       cluster_reset,
   output logic       run_en,
   output logic       cluster_busy,
   output logic       done_irq
);

   localparam int CTR_W = $clog2(RESET_DELAY + 1);

   logic [CTR_W-1:0] reset_ctr;
   logic             launch;
   logic             engines_idle;

   // a start during the reset window is ignored
   assign launch       = start_pulse & ~cluster_reset;
   assign engines_idle = ~|eng_busy;

   //////////////////////////////////////////////////////////////////////
   // multicycle soft reset
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset) begin
         cluster_reset <= 1'b0;
         run_en        <= 1'b0;
         reset_ctr     <= '0;
      end else if (launch) begin
         cluster_reset <= 1'b1;
         run_en        <= 1'b1;
         reset_ctr     <= '0;
      end else if (cluster_reset) begin
         if (reset_ctr == CTR_W'(RESET_DELAY - 1)) begin
            cluster_reset <= 1'b0;
         end else begin
            reset_ctr <= reset_ctr + 1'b1;
         end
      end
   end

   // busy covers the reset window too
   assign cluster_busy = run_en & (cluster_reset | ~engines_idle);

   //////////////////////////////////////////////////////////////////////
   // done interrupt
   //////////////////////////////////////////////////////////////////////

   // sticky until the next launch
   always_ff @(posedge clk) begin
      if (!reset) begin
         done_irq <= 1'b0;
      end else if (launch) begin
         done_irq <= 1'b0;
      end else if (run_en && !cluster_reset && engines_idle) begin
         done_irq <= 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (!reset)
      cluster_reset [*RESET_DELAY] |=> !cluster_reset)
      else $error("cluster reset held longer than RESET_DELAY cycles");

endmodule

/* hw/apb_ctrl_regs.sv */
`timescale 1ns/1ps

module apb_ctrl_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  accel_pkg::word_t     paddr,
   input  accel_pkg::word_t     pwdata,
   output accel_pkg::word_t     prdata,
   output logic                 pready,
   output logic                 pslverr,
   output accel_pkg::mem_addr_t base_offset,
   output logic                 start_pulse,
   input  logic                 cluster_busy,
   input  logic                 done_irq,
   output logic                 cyc,
   output logic                 stb,
   output logic                 we,
   output accel_pkg::mem_addr_t adr,
   output accel_pkg::word_t     dat_w,
   input  logic                 ack,
   input  accel_pkg::word_t     dat_r
);

   logic             win_sel;
   logic             access;
   logic             reg_wr;
   accel_pkg::word_t reg_rdata;

   assign win_sel = paddr[accel_pkg::MEM_WINDOW_BIT];
   assign access  = psel & penable;
   assign reg_wr  = access & pwrite & ~win_sel;

   //////////////////////////////////////////////////////////////////////
   // memory window to wishbone
   //////////////////////////////////////////////////////////////////////

   // one wishbone cycle per apb access phase
   assign cyc   = access & win_sel;
   assign stb   = access & win_sel;
   assign we    = pwrite;
   // byte address on apb, word address on the bus
   assign adr   = paddr[9:2];
   assign dat_w = pwdata;

   // registers are zero-wait, the window waits for ack
   assign pready  = access & (~win_sel | ack);
   assign pslverr = 1'b0;

   //////////////////////////////////////////////////////////////////////
   // control registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset) begin
         base_offset <= '0;
         start_pulse <= 1'b0;
      end else begin
         start_pulse <= 1'b0;
         if (reg_wr) begin
            case (paddr[7:0])
               accel_pkg::REG_BASE_OFFSET: base_offset <= pwdata[7:0];
               accel_pkg::REG_START:       start_pulse <= pwdata[0];
               default: ;
            endcase
         end
      end
   end

   // start is write-only and reads as zero
   always_comb begin
      case (paddr[7:0])
         accel_pkg::REG_BASE_OFFSET: reg_rdata = {24'b0, base_offset};
         accel_pkg::REG_STATUS:      reg_rdata = {30'b0, done_irq, cluster_busy};
         default:                    reg_rdata = '0;
      endcase
   end

   assign prdata = win_sel ? dat_r : reg_rdata;

   // the apb master keeps a window access open until the ack
   assert property (@(posedge clk) disable iff (!reset)
      (stb && !ack) |=> (stb && psel))
      else $error("host window request dropped before ack");

endmodule

/* hw/accel_top.sv */
`timescale 1ns/1ps

module accel_top #(
   parameter int RESET_DELAY = 4,
   parameter int BLOCK_LEN   = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  accel_pkg::word_t paddr,
   input  accel_pkg::word_t pwdata,
   output accel_pkg::word_t prdata,
   output logic             pready,
   output logic             pslverr,
   output logic             done_irq
);

   accel_pkg::mem_addr_t base_offset;
   logic                 start_pulse;
   logic                 cluster_busy;
   logic                 cluster_reset;
   logic                 run_en;
   wire [1:0]            eng_busy;

   // wishbone masters, 0 host window, 1 and 2 engines
   wire [2:0]                      m_cyc;
   wire [2:0]                      m_stb;
   wire [2:0]                      m_we;
   wire accel_pkg::mem_addr_t [2:0] m_adr;
   wire accel_pkg::word_t [2:0]     m_dat_w;
   logic [2:0]                     m_ack;
   accel_pkg::word_t               m_dat_r;

   logic                 s_cyc;
   logic                 s_stb;
   logic                 s_we;
   accel_pkg::mem_addr_t s_adr;
   accel_pkg::word_t     s_dat_w;
   logic                 s_ack;
   accel_pkg::word_t     s_dat_r;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   apb_ctrl_regs u_regs (
      .clk          (clk),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .base_offset  (base_offset),
      .start_pulse  (start_pulse),
      .cluster_busy (cluster_busy),
      .done_irq     (done_irq),
      .cyc          (m_cyc[0]),
      .stb          (m_stb[0]),
      .we           (m_we[0]),
      .adr          (m_adr[0]),
      .dat_w        (m_dat_w[0]),
      .ack          (m_ack[0]),
      .dat_r        (m_dat_r)
   );

   launch_sequencer #(
      .RESET_DELAY (RESET_DELAY)
   ) u_seq (
      .clk           (clk),
      .reset         (reset),
      .start_pulse   (start_pulse),
      .eng_busy      (eng_busy),
      .cluster_reset (cluster_reset),
      .run_en        (run_en),
      .cluster_busy  (cluster_busy),
      .done_irq      (done_irq)
   );

   //////////////////////////////////////////////////////////////////////
   // compute cluster
   //////////////////////////////////////////////////////////////////////

   prefix_sum_engine #(
      .LANE_ID   (0),
      .BLOCK_LEN (BLOCK_LEN)
   ) u_eng0 (
      .clk           (clk),
      .reset         (reset),
      .cluster_reset (cluster_reset),
      .run_en        (run_en),
      .busy          (eng_busy[0]),
      .cyc           (m_cyc[1]),
      .stb           (m_stb[1]),
      .we            (m_we[1]),
      .adr           (m_adr[1]),
      .dat_w         (m_dat_w[1]),
      .ack           (m_ack[1]),
      .dat_r         (m_dat_r)
   );

   prefix_sum_engine #(
      .LANE_ID   (1),
      .BLOCK_LEN (BLOCK_LEN)
   ) u_eng1 (
      .clk           (clk),
      .reset         (reset),
      .cluster_reset (cluster_reset),
      .run_en        (run_en),
      .busy          (eng_busy[1]),
      .cyc           (m_cyc[2]),
      .stb           (m_stb[2]),
      .we            (m_we[2]),
      .adr           (m_adr[2]),
      .dat_w         (m_dat_w[2]),
      .ack           (m_ack[2]),
      .dat_r         (m_dat_r)
   );

   //////////////////////////////////////////////////////////////////////
   // shared memory
   //////////////////////////////////////////////////////////////////////

   wb_arbiter u_arb (
      .clk         (clk),
      .reset       (reset),
      .base_offset (base_offset),
      .m_cyc       (m_cyc),
      .m_stb       (m_stb),
      .m_we        (m_we),
      .m_adr       (m_adr),
      .m_dat_w     (m_dat_w),
      .m_ack       (m_ack),
      .m_dat_r     (m_dat_r),
      .s_cyc       (s_cyc),
      .s_stb       (s_stb),
      .s_we        (s_we),
      .s_adr       (s_adr),
      .s_dat_w     (s_dat_w),
      .s_ack       (s_ack),
      .s_dat_r     (s_dat_r)
   );

   wb_sram u_sram (
      .clk   (clk),
      .reset (reset),
      .cyc   (s_cyc),
      .stb   (s_stb),
      .we    (s_we),
      .adr   (s_adr),
      .dat_w (s_dat_w),
      .ack   (s_ack),
      .dat_r (s_dat_r)
   );

endmodule

/* verification/accel_checker.sv */
`timescale 1ns/1ps

module accel_checker #(
   parameter int BLOCK_LEN = 8
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  accel_pkg::word_t paddr,
   input  accel_pkg::word_t pwdata,
   input  accel_pkg::word_t prdata,
   input  logic             pready,
   input  logic             pslverr,
   input  logic             done_irq
);

   enum {never_run, running, run_done} run_state = never_run;

   accel_pkg::word_t     shadow [256];
   accel_pkg::mem_addr_t base_offset = '0;
   int                   since_start = 3;
   int                   error_count = 0;
   string                test_name   = "reset";

   task automatic set_test_name(input string name);
      test_name = name;
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // sum of the first count words from src, wraps mod 2^32
   function automatic accel_pkg::word_t running_sum(input accel_pkg::mem_addr_t src,
                                                    input int count);
      accel_pkg::word_t sum;
      sum = '0;
      for (int i = 0; i < count; i++) begin
         sum = sum + shadow[accel_pkg::mem_addr_t'(src + i)];
      end
      return sum;
   endfunction

   // destination blocks as the engines leave them after a run
   task automatic apply_launch();
      accel_pkg::mem_addr_t src;
      for (int lane = 0; lane < 2; lane++) begin
         src = accel_pkg::mem_addr_t'(base_offset + lane * accel_pkg::LANE_STRIDE);
         for (int k = 0; k < BLOCK_LEN; k++) begin
            shadow[accel_pkg::mem_addr_t'(src + accel_pkg::DST_OFFSET + k)] =
               running_sum(src, k + 1);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // apb monitor
   //////////////////////////////////////////////////////////////////////

   task automatic compare_read(input accel_pkg::word_t expected);
      if (prdata !== expected) begin
         error_count++;
         $display("Mismatch in %s at paddr %h: expected %h, actual %h",
                  test_name, paddr, expected, prdata);
      end
   endtask

   task automatic check_transfer();
      accel_pkg::mem_addr_t wadr;
      wadr = paddr[9:2];
      if (pslverr) begin
         error_count++;
         $display("pslverr was raised in %s at paddr %h", test_name, paddr);
      end
      if (paddr[accel_pkg::MEM_WINDOW_BIT]) begin
         if (pwrite) begin
            shadow[wadr] = pwdata;
         end else begin
            compare_read(shadow[wadr]);
         end
      end else if (pwrite) begin
         if (paddr[7:0] == accel_pkg::REG_BASE_OFFSET) begin
            base_offset = pwdata[7:0];
         end else if (paddr[7:0] == accel_pkg::REG_START && pwdata[0]) begin
            apply_launch();
            since_start = 0;
            run_state   = running;
         end
      end else begin
         case (paddr[7:0])
            accel_pkg::REG_BASE_OFFSET: compare_read({24'b0, base_offset});
            accel_pkg::REG_STATUS: begin
               case (run_state)
                  running:  compare_read(32'd1);
                  run_done: compare_read(32'd2);
                  default:  compare_read(32'd0);
               endcase
            end
            default: compare_read(32'd0);
         endcase
      end
   endtask

   // inputs change 1 ns after the rising edge, so the falling edge sees them settled
   always @(negedge clk) begin
      if (!reset) begin
         run_state   = never_run;
         since_start = 3;
      end else begin
         if (since_start < 3) begin
            since_start++;
         end
         // launch clears done one cycle after the start pulse
         if (since_start == 2 && done_irq) begin
            error_count++;
            $display("done_irq was still high two cycles after a start in %s", test_name);
         end
         if (run_state == never_run && done_irq) begin
            error_count++;
            $display("done_irq went high before any start in %s", test_name);
         end
         if (run_state == running && since_start >= 2 && done_irq) begin
            run_state = run_done;
         end
         if (psel && penable && pready) begin
            check_transfer();
         end
      end
   end

endmodule

/* verification/tb_accel_top.sv */
`timescale 1ns/1ps

module tb_accel_top;

   localparam int RESET_DELAY = 4;
   localparam int BLOCK_LEN   = 8;
   localparam int N_WIN       = 16;
   // window test, nine lane-pair blocks and fifteen register accesses
   localparam int NUM_ACCESSES = 2 * N_WIN + 9 * 2 * BLOCK_LEN + 15;
   localparam int MAX_CYCLES   = 40 * NUM_ACCESSES + 2000;

   logic             clk;
   logic             reset;
   logic             psel;
   logic             penable;
   logic             pwrite;
   accel_pkg::word_t paddr;
   accel_pkg::word_t pwdata;
   accel_pkg::word_t prdata;
   logic             pready;
   logic             pslverr;
   logic             done_irq;

   integer               seed;
   int                   cycles = 0;
   accel_pkg::mem_addr_t win_adr [N_WIN];

   accel_top #(
      .RESET_DELAY (RESET_DELAY),
      .BLOCK_LEN   (BLOCK_LEN)
   ) dut (
      .clk      (clk),
      .reset    (reset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .done_irq (done_irq)
   );

   accel_checker #(
      .BLOCK_LEN (BLOCK_LEN)
   ) chk (
      .clk      (clk),
      .reset    (reset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .done_irq (done_irq)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, the test sequence was still running after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // apb driver
   //////////////////////////////////////////////////////////////////////

   function automatic accel_pkg::word_t window_addr(input accel_pkg::mem_addr_t a);
      return (32'h1 << accel_pkg::MEM_WINDOW_BIT) | (32'(a) << 2);
   endfunction

   // setup phase, then access phase until pready
   task automatic apb_transfer(input logic write, input accel_pkg::word_t addr,
                               input accel_pkg::word_t data);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      do @(negedge clk); while (!pready);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic load_sources(input accel_pkg::mem_addr_t base);
      for (int lane = 0; lane < 2; lane++) begin
         for (int k = 0; k < BLOCK_LEN; k++) begin
            apb_transfer(1'b1, window_addr(accel_pkg::mem_addr_t'(
               base + lane * accel_pkg::LANE_STRIDE + k)), $random(seed));
         end
      end
   endtask

   task automatic read_lanes(input accel_pkg::mem_addr_t base,
                             input accel_pkg::mem_addr_t rel);
      for (int lane = 0; lane < 2; lane++) begin
         for (int k = 0; k < BLOCK_LEN; k++) begin
            apb_transfer(1'b0, window_addr(accel_pkg::mem_addr_t'(
               base + lane * accel_pkg::LANE_STRIDE + rel + k)), '0);
         end
      end
   endtask

   task automatic wait_done();
      do @(negedge clk); while (!done_irq);
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk     = 1'b0;
      reset   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed    = 59;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b1;

      chk.set_test_name("registers");
      apb_transfer(1'b0, accel_pkg::REG_BASE_OFFSET, '0);
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      apb_transfer(1'b1, accel_pkg::REG_BASE_OFFSET, 32'h0000_00a5);
      apb_transfer(1'b0, accel_pkg::REG_BASE_OFFSET, '0);
      apb_transfer(1'b0, accel_pkg::REG_START, '0);
      apb_transfer(1'b1, accel_pkg::REG_BASE_OFFSET, '0);

      chk.set_test_name("memory window");
      for (int i = 0; i < N_WIN; i++) begin
         win_adr[i] = accel_pkg::mem_addr_t'($random(seed));
         apb_transfer(1'b1, window_addr(win_adr[i]), $random(seed));
      end
      for (int i = 0; i < N_WIN; i++) begin
         apb_transfer(1'b0, window_addr(win_adr[i]), '0);
      end

      chk.set_test_name("launch base 0");
      load_sources(8'd0);
      apb_transfer(1'b1, accel_pkg::REG_START, 32'd1);
      wait_done();
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      read_lanes(8'd0, accel_pkg::DST_OFFSET);
      read_lanes(8'd0, 8'd0);

      chk.set_test_name("launch base 5");
      apb_transfer(1'b1, accel_pkg::REG_BASE_OFFSET, 32'd5);
      load_sources(8'd5);
      apb_transfer(1'b1, accel_pkg::REG_START, 32'd1);
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      wait_done();
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      read_lanes(8'd5, accel_pkg::DST_OFFSET);
      // unshifted blocks from the previous run
      read_lanes(8'd0, accel_pkg::DST_OFFSET);

      chk.set_test_name("restart with host traffic");
      load_sources(8'd5);
      apb_transfer(1'b1, accel_pkg::REG_START, 32'd1);
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      // these reads compete with both engines
      read_lanes(8'd5, 8'd0);
      wait_done();
      apb_transfer(1'b0, accel_pkg::REG_STATUS, '0);
      read_lanes(8'd5, accel_pkg::DST_OFFSET);

      repeat (2) @(posedge clk);
      $display("closing report: %0d errors after %0d cycles", chk.error_count, cycles);
      if (chk.error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* tb.f */
hw/accel_pkg.sv
hw/wb_sram.sv
hw/wb_arbiter.sv
hw/prefix_sum_engine.sv
hw/launch_sequencer.sv
hw/apb_ctrl_regs.sv
hw/accel_top.sv
verification/accel_checker.sv
verification/tb_accel_top.sv

/* Bender.yml */
package:
  name: accel_subsystem

sources:
  # design
  - files:
      - hw/accel_pkg.sv
      - hw/wb_sram.sv
      - hw/wb_arbiter.sv
      - hw/prefix_sum_engine.sv
      - hw/launch_sequencer.sv
      - hw/apb_ctrl_regs.sv
      - hw/accel_top.sv

  # testbench
  - target: test
    files:
      - verification/accel_checker.sv
      - verification/tb_accel_top.sv
